// File: verilog/obj_defs.svh
// size constants for the sprite engine
// include in any file that sizes the table, the rom bus or the line
`ifndef OBJ_DEFS_SVH
`define OBJ_DEFS_SVH

// object table, 1024 words of 16 bits
// 256 entries of four words each
`define OBJ_TABLE_AW 10

// graphics rom word address
// tile id, half, row, low zero
`define OBJ_ROM_AW 18

// line buffer address width, 512 pixels per bank
`define OBJ_LINE_AW 9

// tiles of 16 pixels allowed per line
// roughly what fits in one line time of the original chip
`define OBJ_MAX_TILES 48

`endif

// File: verilog/obj_pkg.sv
// types shared by the sprite engine stages
// scanner records, line buffer writes and the fsm states
`include "obj_defs.svh"

package obj_pkg;

    // one visible sprite as found by the scanner
    typedef struct packed {
        logic [11:0]               tile;   // base tile id
        logic [`OBJ_LINE_AW-1:0]   x;      // screen x of the left pixel
        logic [3:0]                row;    // row inside the tile
        logic [2:0]                col;    // vertical tile offset
        logic [2:0]                nsize;  // tiles across minus one
        logic [1:0]                msize;  // log2 of tiles down
        logic                      hflip;
        logic                      vflip;
        logic [3:0]                pal;
    } obj_attr_t;

    // one pixel write into the draw bank
    typedef struct packed {
        logic                      we;
        logic [`OBJ_LINE_AW-1:0]   addr;
        logic [7:0]                data;   // palette, colour
    } buf_wr_t;

    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_W0,    // flags, size and y
        SCAN_W1,    // tile id
        SCAN_W2,    // palette, blink and x
        SCAN_HOLD   // waiting for the drawer
    } scan_state_t;

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_FETCH,
        DRAW_SHIFT
    } draw_state_t;

endpackage

// File: verilog/obj_table_axil.sv
// object table with an AXI4-Lite slave port for the cpu
// the table sits in the low 16 bits of each 32-bit word
// a second registered read port feeds the line scanner
`include "obj_defs.svh"

module obj_table_axil (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`OBJ_TABLE_AW+1:0]  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`OBJ_TABLE_AW+1:0]  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  logic [`OBJ_TABLE_AW-1:0]  tbl_addr,
    output logic [15:0]               tbl_dout
);

    localparam int DEPTH = 1 << `OBJ_TABLE_AW;

    logic [15:0] mem [DEPTH];
    logic        wr_go;
    logic        rd_go;

    assign wr_go = awvalid && wvalid && awready;  // both channels accepted together
    assign rd_go = arvalid && arready;
    assign wready = awready;
    assign bresp  = 2'b00;
    assign rresp  = 2'b00;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            if (wr_go)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            arready <= arvalid && !arready && !rvalid;
            if (rd_go)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go && wstrb[0]) mem[awaddr[`OBJ_TABLE_AW+1:2]][7:0]  <= wdata[7:0];
        if (wr_go && wstrb[1]) mem[awaddr[`OBJ_TABLE_AW+1:2]][15:8] <= wdata[15:8];
        if (rd_go)
            rdata <= {16'd0, mem[araddr[`OBJ_TABLE_AW+1:2]]};
        tbl_dout <= mem[tbl_addr];  // scanner port
    end

endmodule

// File: verilog/obj_scan.sv
// per-line walk of the object table
// restarts on each falling hs and hands one record per visible sprite
// to the drawer, stalling while the drawer is busy
`include "obj_defs.svh"

module obj_scan import obj_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      hs,
    input  logic                      lvbl,
    input  logic                      flip,
    input  logic [`OBJ_LINE_AW-1:0]   vrender,
    output logic [`OBJ_TABLE_AW-1:0]  tbl_addr,
    input  logic [15:0]               tbl_dout,
    output obj_attr_t                 attr,
    output logic                      attr_valid,
    input  logic                      attr_ready
);

    localparam int TAW = `OBJ_TABLE_AW;
    localparam logic [6:0] MAX_TILES = 7'(`OBJ_MAX_TILES);

    scan_state_t state;
    logic [6:0]  tile_cnt;
    logic        hs_l, lvbl_l, frame, rd_wait, last_ent;
    logic        hs_fall, step, last, inzone, show;
    logic [8:0]  ypos, top, veff;
    logic [2:0]  ncode, cmask;

    assign hs_fall = hs_l && !hs;
    assign step    = !hs_fall && !rd_wait;      // table data valid this cycle
    assign last    = &tbl_addr[TAW-1:2];        // entry 255
    assign ypos    = flip ? tbl_dout[8:0] : 9'd256 - tbl_dout[8:0];
    assign top     = ypos - (9'd16 << tbl_dout[12:11]);
    assign veff    = vrender - top;
    assign inzone  = vrender >= top && vrender < ypos;
    assign show    = !tbl_dout[11] || frame;    // blink hides while the frame bit is low
    // 1, 2, 4, 8 tiles wide as tiles minus one
    assign ncode   = {tbl_dout[10:9] == 2'd3, tbl_dout[10], |tbl_dout[10:9]};
    assign cmask   = {tbl_dout[12:11] == 2'd3, tbl_dout[12], |tbl_dout[12:11]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= SCAN_IDLE;
            tbl_addr   <= '0;
            tile_cnt   <= '0;
            hs_l       <= 1'b0;
            lvbl_l     <= 1'b0;
            frame      <= 1'b0;
            rd_wait    <= 1'b0;
            last_ent   <= 1'b0;
            attr_valid <= 1'b0;
        end else begin
            hs_l    <= hs;
            lvbl_l  <= lvbl;
            rd_wait <= 1'b0;
            if (lvbl_l && !lvbl) frame <= ~frame;
            if (hs_fall) begin
                state      <= SCAN_W0;
                tbl_addr   <= '0;
                tile_cnt   <= '0;
                rd_wait    <= 1'b1;
                attr_valid <= 1'b0;
            end else if (step || state == SCAN_HOLD) begin  // hold sees ready every cycle
                case (state)
                    SCAN_W0: begin
                        if (tile_cnt >= MAX_TILES) begin
                            state <= SCAN_IDLE;     // line full
                        end else if (!tbl_dout[15] || !inzone) begin
                            tbl_addr <= tbl_addr + TAW'(4);
                            rd_wait  <= 1'b1;
                            if (last) state <= SCAN_IDLE;
                        end else begin
                            tbl_addr <= tbl_addr + TAW'(1);
                            rd_wait  <= 1'b1;
                            state    <= SCAN_W1;
                        end
                    end
                    SCAN_W1: begin
                        tbl_addr <= tbl_addr + TAW'(1);
                        rd_wait  <= 1'b1;
                        state    <= SCAN_W2;
                    end
                    SCAN_W2: begin
                        tbl_addr <= tbl_addr + TAW'(2); // skip word 3
                        rd_wait  <= 1'b1;
                        last_ent <= last;
                        if (show) begin
                            attr_valid <= 1'b1;
                            tile_cnt   <= tile_cnt + {4'd0, attr.nsize} + 7'd1;
                            state      <= SCAN_HOLD;
                        end else begin
                            state <= last ? SCAN_IDLE : SCAN_W0;
                        end
                    end
                    SCAN_HOLD: begin
                        if (attr_ready) begin
                            attr_valid <= 1'b0;
                            state      <= last_ent ? SCAN_IDLE : SCAN_W0;
                        end
                    end
                    default: state <= SCAN_IDLE;
                endcase
            end
        end
    end

    // record fields fill in as the words go by
    always_ff @(posedge clk) begin
        if (step && state == SCAN_W0) begin
            {attr.vflip, attr.hflip} <= tbl_dout[14:13] ^ {2{flip}};
            attr.msize <= tbl_dout[12:11];
            attr.nsize <= ncode;
            attr.row   <= veff[3:0];
            attr.col   <= veff[6:4] & cmask;
        end
        if (step && state == SCAN_W1) attr.tile <= tbl_dout[11:0];
        if (step && state == SCAN_W2) begin
            attr.pal <= tbl_dout[15:12];
            attr.x   <= flip ? tbl_dout[8:0] : 9'd240 - tbl_dout[8:0];
        end
    end

endmodule

// File: verilog/obj_draw.sv
// sprite drawer
// takes one record at a time, fetches each half tile from the
// graphics rom and shifts its 8 pixels out to the line buffer
`include "obj_defs.svh"

module obj_draw import obj_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  obj_attr_t                attr,
    input  logic                     attr_valid,
    output logic                     attr_ready,
    output logic                     rom_cs,
    output logic [`OBJ_ROM_AW-1:0]   rom_addr,
    input  logic [31:0]              rom_data,
    input  logic                     rom_ok,
    output buf_wr_t                  buf_wr
);

    draw_state_t             state;
    obj_attr_t               cur;
    logic [31:0]             data;
    logic [`OBJ_LINE_AW-1:0] xaddr;
    logic [2:0]              pcnt, ncnt;
    logic                    half, ok_l;
    logic                    start, take, shifting, half_end;
    logic [3:0]              pix;

    assign attr_ready = state == DRAW_IDLE;
    assign start      = attr_ready && attr_valid;
    assign take       = state == DRAW_FETCH && rom_ok && ok_l;  // second ok in a row
    assign shifting   = state == DRAW_SHIFT;
    assign half_end   = shifting && pcnt == 3'd0;

    // four planes, one bit each from every byte of the word
    assign pix = cur.hflip ? {data[8], data[24], data[0], data[16]}
                           : {data[15], data[31], data[7], data[23]};

    assign buf_wr = '{we: shifting, addr: xaddr, data: {cur.pal, pix}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= DRAW_IDLE;
            rom_cs <= 1'b0;
            ok_l   <= 1'b0;
            half   <= 1'b0;
            pcnt   <= '0;
            ncnt   <= '0;
        end else begin
            ok_l <= state == DRAW_FETCH && rom_ok;
            if (start) begin
                ncnt   <= attr.nsize;
                half   <= 1'b0;
                rom_cs <= 1'b1;
                state  <= DRAW_FETCH;
            end
            if (take) begin
                rom_cs <= 1'b0;
                ok_l   <= 1'b0;
                pcnt   <= 3'd7;
                state  <= DRAW_SHIFT;
            end
            if (shifting) pcnt <= pcnt - 3'd1;
            if (half_end) begin
                if (half && ncnt == 3'd0) begin
                    state <= DRAW_IDLE;         // sprite done
                end else begin
                    half   <= ~half;
                    rom_cs <= 1'b1;
                    state  <= DRAW_FETCH;
                    if (half) ncnt <= ncnt - 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur      <= attr;
            xaddr    <= attr.x;
            rom_addr <= {attr.tile + 12'(attr.col), ~attr.hflip,
                         attr.row ^ {4{attr.vflip}}, 1'b0};
        end
        if (take) data <= rom_data;
        if (shifting) begin
            data  <= cur.hflip ? data >> 1 : data << 1;
            xaddr <= xaddr + 1'b1;
        end
        if (half_end && !half) rom_addr[5] <= ~rom_addr[5];  // other 8 pixels
        if (half_end && half && ncnt != 3'd0) begin
            rom_addr[17:6] <= rom_addr[17:6] + (12'd1 << cur.msize);
            rom_addr[5]    <= ~cur.hflip;
        end
    end

endmodule

// File: verilog/obj_line_buffer.sv
// double line buffer for the sprite pixels
// one bank takes drawer writes while the other is read at the beam
// and erased behind it, banks swap on each falling hs
`include "obj_defs.svh"

module obj_line_buffer import obj_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    hs,
    input  logic                    lhbl,
    input  logic                    pxl_cen,
    input  buf_wr_t                 buf_wr,
    input  logic [`OBJ_LINE_AW-1:0] hdump,
    output logic [7:0]              pxl
);

    localparam int DEPTH = 1 << `OBJ_LINE_AW;

    logic       bank, hs_l;     // bank is the one being drawn
    logic [7:0] rd_data [2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
            hs_l <= 1'b0;
            pxl  <= 8'd0;
        end else begin
            hs_l <= hs;
            if (hs_l && !hs) bank <= ~bank;
            if (pxl_cen) pxl <= rd_data[~bank];
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [7:0] mem [DEPTH];

        always_ff @(posedge clk) begin
            if (bank == 1'(b)) begin
                if (buf_wr.we && buf_wr.data[3:0] != 4'd0)  // colour 0 is see-through
                    mem[buf_wr.addr] <= buf_wr.data;
            end else if (pxl_cen && lhbl) begin
                mem[hdump] <= 8'd0;     // clear behind the beam
            end
        end

        assign rd_data[b] = mem[hdump];
    end

endmodule

// File: verilog/obj_engine.sv
// scanline sprite engine top
// cpu loads the object table over AXI4-Lite, sprites come out at pxl
// one line after the line on which they were found
`include "obj_defs.svh"

module obj_engine import obj_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`OBJ_TABLE_AW+1:0]  awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`OBJ_TABLE_AW+1:0]  araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  logic                      pxl_cen,
    input  logic                      hs,
    input  logic                      lhbl,
    input  logic                      lvbl,
    input  logic                      flip,
    input  logic [`OBJ_LINE_AW-1:0]   hdump,
    input  logic [`OBJ_LINE_AW-1:0]   vrender,
    output logic                      rom_cs,
    output logic [`OBJ_ROM_AW-1:0]    rom_addr,
    input  logic [31:0]               rom_data,
    input  logic                      rom_ok,
    output logic [7:0]                pxl
);

    logic [`OBJ_TABLE_AW-1:0] tbl_addr;
    logic [15:0]              tbl_dout;
    obj_attr_t                attr;
    logic                     attr_valid, attr_ready;
    buf_wr_t                  buf_wr;

    obj_table_axil u_table (.*);

    obj_scan u_scan (.*);

    obj_draw u_draw (.*);

    obj_line_buffer u_buffer (.*);

endmodule

// File: testbench/obj_engine_tb.sv
// testbench for the sprite engine
// loads the object table over AXI4-Lite, serves the graphics rom with
// random latency and checks each visible pixel against a line model
// built from a copy of the table
`include "obj_defs.svh"

module obj_engine_tb;

    localparam int LINE_CLK = 4096;     // long hblank so a full line of tiles fits
    localparam int MAX_LINES = 90;
    localparam int WATCHDOG = MAX_LINES * LINE_CLK * 8 + 50000;

    logic        clk = 1'b0;
    logic        rst;
    logic [11:0] awaddr, araddr;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata, rom_data;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        pxl_cen, hs, lhbl, lvbl, flip, rom_cs, rom_ok;
    logic [8:0]  hdump, vrender;
    logic [17:0] rom_addr;
    logic [7:0]  pxl;

    logic [15:0] tbl [1024];            // copy of what the cpu wrote
    logic [7:0]  cur_exp [512];
    logic [7:0]  pend_exp [512];
    logic        cur_ok, pend_ok, dirty, checking, frame, prev_cen;
    logic [8:0]  prev_h;
    logic [31:0] rng = 32'hd2ec_e53c;
    int          cc, line_no, rom_wait, errors, checked;
    string       test_name;

    obj_engine u_dut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] v);
        v ^= v << 13;
        v ^= v >> 17;
        v ^= v << 5;
        return v;
    endfunction

    function automatic logic [31:0] rom_word(input logic [17:0] a);
        return xorshift(xorshift({14'd0, a} ^ 32'h5bd1_e995));
    endfunction

    // expected line from the table rules where later writes win
    task automatic build_line(input logic [8:0] vr, input logic flp, input logic frm);
        int          cnt, nw, h;
        logic [15:0] w0, w1, w2;
        logic [8:0]  ypos, top, veff, xs, pos;
        logic [3:0]  row, colr;
        logic [2:0]  col;
        logic [11:0] t;
        logic        hf, vf, hb;
        logic [31:0] d;
        for (int i = 0; i < 512; i++) pend_exp[i] = 8'd0;
        cnt = 0;
        for (int e = 0; e < 256 && cnt < `OBJ_MAX_TILES; e++) begin
            w0 = tbl[4*e];
            w1 = tbl[4*e+1];
            w2 = tbl[4*e+2];
            ypos = flp ? w0[8:0] : 9'(10'd256 - {1'b0, w0[8:0]});
            h = 1 << w0[12:11];
            top = ypos - 9'(16 * h);
            if (!w0[15] || vr < top || vr >= ypos) continue;
            if (w2[11] && !frm) continue;   // blink hidden on this frame
            nw = 1 << w0[10:9];
            cnt += nw;
            veff = vr - top;
            row = veff[3:0];
            col = veff[6:4] & 3'(h - 1);
            hf = w0[13] ^ flp;
            vf = w0[14] ^ flp;
            xs = flp ? w2[8:0] : 9'(9'd240 - w2[8:0]);
            for (int n = 0; n < nw; n++) begin
                t = w1[11:0] + 12'(col) + 12'(n * h);
                for (int hl = 0; hl < 2; hl++) begin
                    hb = !hf ^ (hl == 1);
                    d = rom_word({t, hb, row ^ {4{vf}}, 1'b0});
                    for (int k = 0; k < 8; k++) begin
                        colr = hf ? {d[8+k], d[24+k], d[k], d[16+k]}
                                  : {d[15-k], d[31-k], d[7-k], d[23-k]};
                        pos = xs + 9'(16 * n + 8 * hl + k);
                        if (colr != 4'd0) pend_exp[pos] = {w2[15:12], colr};
                    end
                end
            end
        end
    endtask

    // video timing, line model and pixel checks
    always @(negedge clk) begin
        if (prev_cen && prev_h < 9'd256 && cur_ok) begin
            checked++;
            assert (pxl == cur_exp[prev_h]) else begin
                errors++;
                $display("ERROR %s: line %0d pixel %0d expected %02h actual %02h",
                         test_name, line_no, prev_h, cur_exp[prev_h], pxl);
            end
        end
        prev_cen = pxl_cen;
        prev_h = hdump;
        cc = (cc == LINE_CLK - 1) ? 0 : cc + 1;
        if (cc == 0) begin
            line_no++;
            cur_exp = pend_exp;
            cur_ok = pend_ok && !dirty;     // walk saw a stable table
            vrender = 9'(64 + line_no);
            build_line(vrender, flip, frame);
            pend_ok = checking;
            dirty = 1'b0;
        end
        if (cc == LINE_CLK - 16) begin
            if (lvbl && line_no % 4 == 2) frame = ~frame;
            lvbl = line_no % 4 != 2;        // one low line in four
        end
        hdump = (cc < 768) ? 9'(cc / 2) : 9'd383;
        pxl_cen = cc < 768 && cc % 2 == 1;
        lhbl = cc < 512;
        hs = cc >= LINE_CLK - 64;
    end

    // graphics rom with 1 to 5 cycles of latency
    always @(negedge clk) begin
        if (!rom_cs) begin
            rom_ok = 1'b0;
            rom_wait = -1;
        end else begin
            if (rom_wait < 0) begin
                rng = xorshift(rng);
                rom_wait = 1 + int'(rng % 5);
            end
            if (rom_wait > 0) begin
                rom_wait--;
            end else begin
                rom_ok = 1'b1;
                rom_data = rom_word(rom_addr);
            end
        end
    end

    task automatic set_word(input int idx, input logic [15:0] v);
        tbl[idx] = v;
        dirty = 1'b1;
        awaddr = 12'(idx * 4);
        wdata = {16'(idx) ^ 16'ha5c3, v};   // high half must be ignored
        awvalid = 1'b1;
        wvalid = 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid) @(negedge clk);
        assert (bresp == 2'b00) else begin
            errors++;
            $display("ERROR %s: bresp expected 0 actual %0d", test_name, bresp);
        end
        dirty = 1'b1;
        @(negedge clk);
    endtask

    task automatic read_word(input int idx, output logic [31:0] v, output logic [1:0] r);
        araddr = 12'(idx * 4);
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        v = rdata;
        r = rresp;
        @(negedge clk);
    endtask

    // sprite given in screen terms and converted for the current flip
    task automatic set_sprite(input int e, input logic en, input logic vf, input logic hf,
                              input logic [1:0] ms, input logic [1:0] ns,
                              input logic [8:0] top, input logic [11:0] tile,
                              input logic [3:0] pal, input logic blink,
                              input logic [8:0] xs);
        logic [8:0] ypos, y, x;
        ypos = top + (9'd16 << ms);
        y = flip ? ypos : 9'(10'd256 - {1'b0, ypos});
        x = flip ? xs : 9'd240 - xs;
        set_word(4 * e, {en, vf, hf, ms, ns, y});
        set_word(4 * e + 1, {4'd0, tile});
        set_word(4 * e + 2, {pal, blink, 2'b00, x});
    endtask

    task automatic set_flip(input logic f);
        flip = f;
        dirty = 1'b1;
    endtask

    task automatic wait_lines(input int n);
        int target;
        target = line_no + n;
        while (line_no < target) @(negedge clk);
    endtask

    initial begin
        #(WATCHDOG);
        $display("watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [1:0]  rr;
        rst = 1'b1;
        {awaddr, araddr, wdata, wstrb} = '0;
        {awvalid, wvalid, arvalid} = '0;
        bready = 1'b1;
        rready = 1'b1;
        wstrb = 4'hf;
        {pxl_cen, hs, lhbl, flip, rom_ok} = '0;
        lvbl = 1'b1;
        rom_data = '0;
        hdump = '0;
        vrender = 9'd64;
        {cur_ok, pend_ok, dirty, checking, frame, prev_cen} = '0;
        prev_h = '0;
        {cc, line_no, errors, checked} = '0;
        rom_wait = -1;
        for (int i = 0; i < 1024; i++) tbl[i] = 16'd0;
        test_name = "table_clear";
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int e = 0; e < 256; e++) set_word(4 * e, 16'd0);
        checking = 1'b1;

        test_name = "axi_rw";
        set_word(1023, 16'h1234);
        read_word(1023, rd, rr);
        assert (rd == 32'h0000_1234 && rr == 2'b00) else begin
            errors++;
            $display("ERROR %s: expected 00001234/0 actual %08h/%0d", test_name, rd, rr);
        end

        test_name = "single_tile";
        set_sprite(0, 1, 0, 0, 0, 0, vrender - 9'd2, 12'h010, 4'h5, 0, 9'd40);
        wait_lines(4);
        test_name = "erase";
        set_word(0, 16'd0);
        wait_lines(3);

        test_name = "flips";
        for (int s = 0; s < 2; s++) begin
            for (int hv = 0; hv < 4; hv++) begin
                set_flip(s == 1);
                set_sprite(0, 1, hv[1], hv[0], 0, 1, vrender - 9'd3, 12'(32 + hv),
                           4'h9, 0, 9'(60 + 10 * hv));
                wait_lines(3);
            end
        end
        set_flip(0);

        test_name = "big_sprites";
        set_sprite(0, 1, 0, 0, 2, 3, vrender - 9'd20, 12'h100, 4'h3, 0, 9'd112);
        set_sprite(1, 1, 1, 1, 2, 3, vrender - 9'd40, 12'h200, 4'h7, 0, 9'd0);
        set_sprite(2, 1, 0, 1, 1, 1, vrender - 9'd5, 12'h300, 4'hc, 0, 9'd100);
        wait_lines(5);

        test_name = "visibility";
        set_sprite(0, 0, 0, 0, 0, 0, vrender - 9'd2, 12'h400, 4'h1, 0, 9'd10);
        set_sprite(1, 1, 0, 0, 0, 0, vrender + 9'd40, 12'h410, 4'h2, 0, 9'd50);
        set_sprite(2, 1, 0, 0, 3, 0, vrender - 9'd4, 12'h420, 4'h4, 1, 9'd90);
        set_sprite(3, 1, 1, 0, 3, 1, vrender - 9'd8, 12'h430, 4'h6, 0, 9'd150);
        wait_lines(12);
        for (int e = 0; e < 4; e++) set_word(4 * e, 16'd0);

        test_name = "tile_limit";
        for (int e = 0; e < 60; e++)
            set_sprite(e, 1, 0, 0, 0, 0, vrender - 9'(1 + e % 4), 12'(3 * e),
                       4'(e), 0, 9'(4 * e));
        wait_lines(4);

        $display("errors %0d, pixels checked %0d", errors, checked);
        if (errors == 0 && checked > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/obj_pkg.sv
verilog/obj_table_axil.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_line_buffer.sv
verilog/obj_engine.sv
testbench/obj_engine_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the sprite engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f all.f --top-module obj_engine_tb -o obj_engine_sim

out=$(./obj_dir/obj_engine_sim)
echo "$out"
echo "$out" | grep -qx "Testbench passed"
